// ==== Makefile ====
# Verilator flow for the single-clock FIFO
# every variable can be overridden on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FLIST      ?= fifo_sc.f
RTL_TOP    ?= fifo_sc
TB_TOP     ?= fifo_sc_tb
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= TESTS PASSED
RTL_SRCS   ?= $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== fifo_sc.f ====
src/fifo_geom_pkg.sv
src/fifo_reg_pkg.sv
src/fifo_thresh_regs.sv
src/fifo_flag_gen.sv
src/fifo_ptr_ctrl.sv
src/fifo_ram.sv
src/fifo_sc.sv
verif/fifo_sc_tb.sv

// ==== src/fifo_flag_gen.sv ====
// FIFO flag generator
// qualifies write and read requests with full and empty, registers the
// level flags from the next count and raises the ack, valid and error
// strobes for one cycle
`timescale 1ns/1ps

module fifo_flag_gen #(
   parameter int DEPTH = 16
) (
   input  logic                              pos_clk,
   input  logic                              aresetn,
   input  logic                              we_i,          // write request
   input  logic                              re_i,          // read request
   input  logic [$clog2(DEPTH+1)-1:0]        count_nxt_i,   // count after this cycle
   input  logic [fifo_reg_pkg::THRESH_W-1:0] afull_thr_i,
   input  logic [fifo_reg_pkg::THRESH_W-1:0] aempty_thr_i,
   output logic                              wr_acc_o,      // accepted write
   output logic                              rd_acc_o,      // accepted read
   output logic                              full_o,
   output logic                              empty_o,
   output logic                              afull_o,
   output logic                              aempty_o,
   output logic                              wack_o,
   output logic                              dvld_o,
   output logic                              overflow_o,
   output logic                              underflow_o
);

   import fifo_reg_pkg::*;

   localparam int CNT_W = $clog2(DEPTH+1);
   // compare width wide enough for both count and threshold
   localparam int CMP_W = (CNT_W > THRESH_W) ? CNT_W : THRESH_W;

   logic [CMP_W-1:0] cnt_cmp;          // zero-extended next count
   logic [CMP_W-1:0] afull_cmp;
   logic [CMP_W-1:0] aempty_cmp;
   logic             full_nxt;
   logic             empty_nxt;
   logic             afull_nxt;
   logic             aempty_nxt;

   // ------------------------------------------------------------------
   // request qualification
   // ------------------------------------------------------------------
   // registered flags gate the requests, so a full FIFO never takes a
   // write even if a read happens in the same cycle
   assign wr_acc_o = we_i & ~full_o;
   assign rd_acc_o = re_i & ~empty_o;

   // ------------------------------------------------------------------
   // next flag values
   // ------------------------------------------------------------------
   assign cnt_cmp    = CMP_W'(count_nxt_i);
   assign afull_cmp  = CMP_W'(afull_thr_i);
   assign aempty_cmp = CMP_W'(aempty_thr_i);

   assign full_nxt   = (count_nxt_i == CNT_W'(DEPTH));
   assign empty_nxt  = (count_nxt_i == '0);
   assign afull_nxt  = (cnt_cmp >= afull_cmp);    // at or above level
   assign aempty_nxt = (cnt_cmp <= aempty_cmp);   // at or below level

   // ------------------------------------------------------------------
   // level flags
   // ------------------------------------------------------------------
   // updated every cycle, so a threshold rewrite shows up even while
   // the count stands still
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o   <= 1'b0;
         empty_o  <= 1'b1;
         afull_o  <= 1'b0;
         aempty_o <= 1'b1;
      end else begin
         full_o   <= full_nxt;
         empty_o  <= empty_nxt;
         afull_o  <= afull_nxt;
         aempty_o <= aempty_nxt;
      end
   end

   // ------------------------------------------------------------------
   // one-cycle strobes
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         wack_o      <= wr_acc_o;          // write landed in the RAM
         dvld_o      <= rd_acc_o;          // aligned with registered rdata
         overflow_o  <= we_i & full_o;     // rejected write
         underflow_o <= re_i & empty_o;    // rejected read
      end
   end

endmodule : fifo_flag_gen

// ==== src/fifo_geom_pkg.sv ====
// FIFO geometry defaults
// default depth, data width and the reset values of the almost-full and
// almost-empty thresholds, used as top-level parameter defaults
package fifo_geom_pkg;

   // ------------------------------------------------------------------
   // storage geometry
   // ------------------------------------------------------------------
   localparam int DEF_DEPTH  = 16;   // entries
   localparam int DEF_DATA_W = 8;    // bits per entry

   // ------------------------------------------------------------------
   // threshold reset values
   // ------------------------------------------------------------------
   // afull asserts once the count reaches this level
   localparam int DEF_AFULL  = 12;
   // aempty asserts while the count is at or below this level
   localparam int DEF_AEMPTY = 3;

endpackage : fifo_geom_pkg

// ==== src/fifo_ptr_ctrl.sv ====
// FIFO pointer and occupancy control
// wrapping write and read addresses plus a binary occupancy count that
// rises on accepted writes and falls on accepted reads
`timescale 1ns/1ps

module fifo_ptr_ctrl #(
   parameter int DEPTH = 16
) (
   input  logic                       pos_clk,
   input  logic                       aresetn,
   input  logic                       wr_acc_i,      // accepted write
   input  logic                       rd_acc_i,      // accepted read
   output logic [$clog2(DEPTH)-1:0]   waddr_o,
   output logic [$clog2(DEPTH)-1:0]   raddr_o,
   output logic [$clog2(DEPTH+1)-1:0] count_nxt_o,   // count after this cycle
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   localparam int ADDR_W = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH+1);

   // last valid address, where both pointers wrap back to 0
   localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(DEPTH-1);

   logic [ADDR_W-1:0] waddr_inc;
   logic [ADDR_W-1:0] raddr_inc;
   logic [CNT_W-1:0]  wr_step;
   logic [CNT_W-1:0]  rd_step;

   // ------------------------------------------------------------------
   // address increment with wrap
   // ------------------------------------------------------------------
   // explicit compare instead of natural rollover, so depths that are
   // not a power of two still cycle through 0..DEPTH-1
   assign waddr_inc = (waddr_o == ADDR_LAST) ? '0 : waddr_o + ADDR_W'(1);
   assign raddr_inc = (raddr_o == ADDR_LAST) ? '0 : raddr_o + ADDR_W'(1);

   // ------------------------------------------------------------------
   // write address
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_o <= '0;
      end else if (wr_acc_i) begin
         waddr_o <= waddr_inc;
      end
   end

   // ------------------------------------------------------------------
   // read address
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         raddr_o <= '0;
      end else if (rd_acc_i) begin
         raddr_o <= raddr_inc;
      end
   end

   // ------------------------------------------------------------------
   // occupancy count
   // ------------------------------------------------------------------
   assign wr_step = CNT_W'(wr_acc_i);
   assign rd_step = CNT_W'(rd_acc_i);

   // write plus read cancel out, count holds
   // flags accept-gated, so this never leaves 0..DEPTH
   assign count_nxt_o = count_o + wr_step - rd_step;

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_o <= '0;
      end else begin
         count_o <= count_nxt_o;
      end
   end

endmodule : fifo_ptr_ctrl

// ==== src/fifo_ram.sv ====
// FIFO storage
// dual-port array, synchronous write and registered read
`timescale 1ns/1ps

module fifo_ram #(
   parameter int DEPTH  = 16,
   parameter int DATA_W = 8
) (
   input  logic                     pos_clk,
   input  logic                     we_i,       // write strobe
   input  logic [$clog2(DEPTH)-1:0] waddr_i,
   input  logic [DATA_W-1:0]        wdata_i,
   input  logic                     re_i,       // read strobe
   input  logic [$clog2(DEPTH)-1:0] raddr_i,
   output logic [DATA_W-1:0]        rdata_o     // valid the cycle after re_i
);

   logic [DATA_W-1:0] mem [DEPTH];

   // ------------------------------------------------------------------
   // write port
   // ------------------------------------------------------------------
   always_ff @(posedge pos_clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // ------------------------------------------------------------------
   // read port
   // ------------------------------------------------------------------
   // output register holds the last word between reads
   always_ff @(posedge pos_clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule : fifo_ram

// ==== src/fifo_reg_pkg.sv ====
// FIFO config register definitions
// select encoding and value width of the threshold registers
package fifo_reg_pkg;

   // ------------------------------------------------------------------
   // register select
   // ------------------------------------------------------------------
   typedef enum logic {
      REG_AFULL  = 1'b0,   // almost-full threshold
      REG_AEMPTY = 1'b1    // almost-empty threshold
   } thresh_sel_e;

   // ------------------------------------------------------------------
   // value width
   // ------------------------------------------------------------------
   // 8 bits is enough for depths up to 255
   localparam int THRESH_W = 8;

endpackage : fifo_reg_pkg

// ==== src/fifo_sc.sv ====
// single-clock FIFO top level
// wires the threshold registers, flag generator, pointer control and
// storage array together
`timescale 1ns/1ps

module fifo_sc #(
   parameter int DEPTH        = fifo_geom_pkg::DEF_DEPTH,
   parameter int DATA_W       = fifo_geom_pkg::DEF_DATA_W,
   parameter int AFULL_RESET  = fifo_geom_pkg::DEF_AFULL,
   parameter int AEMPTY_RESET = fifo_geom_pkg::DEF_AEMPTY
) (
   input  logic                              pos_clk,
   input  logic                              aresetn,
   // write side
   input  logic                              we_i,
   input  logic [DATA_W-1:0]                 wdata_i,
   // read side
   input  logic                              re_i,
   output logic [DATA_W-1:0]                 rdata_o,
   output logic                              dvld_o,
   // config side
   input  logic                              cfg_we_i,
   input  fifo_reg_pkg::thresh_sel_e         cfg_sel_i,
   input  logic [fifo_reg_pkg::THRESH_W-1:0] cfg_wdata_i,
   // status
   output logic                              full_o,
   output logic                              empty_o,
   output logic                              afull_o,
   output logic                              aempty_o,
   output logic [$clog2(DEPTH+1)-1:0]        count_o,
   output logic                              wack_o,
   output logic                              overflow_o,
   output logic                              underflow_o
);

   import fifo_reg_pkg::*;

   localparam int ADDR_W = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH+1);

   logic                wr_acc;       // write taken this cycle
   logic                rd_acc;       // read taken this cycle
   logic [ADDR_W-1:0]   waddr;
   logic [ADDR_W-1:0]   raddr;
   logic [CNT_W-1:0]    count_nxt;
   logic [THRESH_W-1:0] afull_thr;
   logic [THRESH_W-1:0] aempty_thr;

   // ------------------------------------------------------------------
   // threshold registers
   // ------------------------------------------------------------------
   fifo_thresh_regs #(
      .AFULL_RESET  (AFULL_RESET),
      .AEMPTY_RESET (AEMPTY_RESET)
   ) fifo_thresh_regs_inst (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .cfg_we_i     (cfg_we_i),
      .cfg_sel_i    (cfg_sel_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .afull_thr_o  (afull_thr),
      .aempty_thr_o (aempty_thr)
   );

   // ------------------------------------------------------------------
   // acceptance, flags and strobes
   // ------------------------------------------------------------------
   fifo_flag_gen #(
      .DEPTH        (DEPTH)
   ) fifo_flag_gen_inst (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .we_i         (we_i),
      .re_i         (re_i),
      .count_nxt_i  (count_nxt),
      .afull_thr_i  (afull_thr),
      .aempty_thr_i (aempty_thr),
      .wr_acc_o     (wr_acc),
      .rd_acc_o     (rd_acc),
      .full_o       (full_o),
      .empty_o      (empty_o),
      .afull_o      (afull_o),
      .aempty_o     (aempty_o),
      .wack_o       (wack_o),
      .dvld_o       (dvld_o),
      .overflow_o   (overflow_o),
      .underflow_o  (underflow_o)
   );

   // ------------------------------------------------------------------
   // addresses and occupancy
   // ------------------------------------------------------------------
   fifo_ptr_ctrl #(
      .DEPTH       (DEPTH)
   ) fifo_ptr_ctrl_inst (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_acc_i    (wr_acc),
      .rd_acc_i    (rd_acc),
      .waddr_o     (waddr),
      .raddr_o     (raddr),
      .count_nxt_o (count_nxt),
      .count_o     (count_o)
   );

   // ------------------------------------------------------------------
   // storage
   // ------------------------------------------------------------------
   fifo_ram #(
      .DEPTH   (DEPTH),
      .DATA_W  (DATA_W)
   ) fifo_ram_inst (
      .pos_clk (pos_clk),
      .we_i    (wr_acc),
      .waddr_i (waddr),
      .wdata_i (wdata_i),
      .re_i    (rd_acc),
      .raddr_i (raddr),
      .rdata_o (rdata_o)
   );

endmodule : fifo_sc

// ==== src/fifo_thresh_regs.sv ====
// FIFO threshold registers
// holds the almost-full and almost-empty levels, loaded from
// parameter values on reset and rewritable through the config port
`timescale 1ns/1ps

module fifo_thresh_regs #(
   parameter int AFULL_RESET  = 12,
   parameter int AEMPTY_RESET = 3
) (
   input  logic                              pos_clk,
   input  logic                              aresetn,
   input  logic                              cfg_we_i,     // config write strobe
   input  fifo_reg_pkg::thresh_sel_e         cfg_sel_i,    // which threshold
   input  logic [fifo_reg_pkg::THRESH_W-1:0] cfg_wdata_i,
   output logic [fifo_reg_pkg::THRESH_W-1:0] afull_thr_o,
   output logic [fifo_reg_pkg::THRESH_W-1:0] aempty_thr_o
);

   import fifo_reg_pkg::*;

   // ------------------------------------------------------------------
   // reset values, sized to the register width
   // ------------------------------------------------------------------
   localparam logic [THRESH_W-1:0] AFULL_INIT  = THRESH_W'(AFULL_RESET);
   localparam logic [THRESH_W-1:0] AEMPTY_INIT = THRESH_W'(AEMPTY_RESET);

   // ------------------------------------------------------------------
   // register write
   // ------------------------------------------------------------------
   // new value is seen by the flag logic from the next cycle on
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         afull_thr_o  <= AFULL_INIT;
         aempty_thr_o <= AEMPTY_INIT;
      end else if (cfg_we_i) begin
         case (cfg_sel_i)
            REG_AFULL: begin
               afull_thr_o <= cfg_wdata_i;
            end
            REG_AEMPTY: begin
               aempty_thr_o <= cfg_wdata_i;
            end
         endcase
      end
   end

endmodule : fifo_thresh_regs

// ==== verif/fifo_sc_tb.sv ====
// testbench for the single-clock FIFO
// LFSR-driven traffic checked each cycle against a queue model
`timescale 1ns/1ps

module fifo_sc_tb;

   import fifo_reg_pkg::*;

   localparam int DEPTH = fifo_geom_pkg::DEF_DEPTH;

   logic                       pos_clk = 1'b0;
   logic                       aresetn;
   logic                       we_i, re_i, dvld_o, cfg_we_i;
   logic [7:0]                 wdata_i, rdata_o, cfg_wdata_i;
   thresh_sel_e                cfg_sel_i;
   logic                       full_o, empty_o, afull_o, aempty_o;
   logic                       wack_o, overflow_o, underflow_o;
   logic [$clog2(DEPTH+1)-1:0] count_o;

   logic [15:0] lfsr_state = 16'd23446;
   logic [7:0]  mdl_q[$];              // reference queue
   logic        m_full, m_empty, m_afull, m_aempty;
   logic        exp_wack, exp_dvld, exp_ovf, exp_unf;
   logic [7:0]  exp_rdata;
   int          m_afull_thr, m_aempty_thr;
   int          errors = 0, checks = 0, tests_run = 0, tests_failed = 0, err_mark = 0;
   int          n;

   fifo_sc fifo_sc_inst (.*);

   always #20 pos_clk = ~pos_clk;      // 40 ns period

   // ----------------------------------------------------------------------
   // random source, x^16 + x^14 + x^13 + x^11 + 1
   // ----------------------------------------------------------------------
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] rand_bits(input int nbits);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < nbits; i++) r = {r[6:0], lfsr_bit()};   // one step per bit
      return r;
   endfunction

   // ----------------------------------------------------------------------
   // model and checks
   // ----------------------------------------------------------------------
   // called at the edge where the DUT samples the inputs driven last cycle
   task automatic update_model();
      logic wacc, racc;
      wacc     = we_i & ~m_full;
      racc     = re_i & ~m_empty;
      exp_ovf  = we_i & m_full;
      exp_unf  = re_i & m_empty;
      exp_wack = wacc;
      exp_dvld = racc;
      if (racc) exp_rdata = mdl_q.pop_front();
      if (wacc) mdl_q.push_back(wdata_i);
      m_full   = (mdl_q.size() == DEPTH);
      m_empty  = (mdl_q.size() == 0);
      m_afull  = (mdl_q.size() >= m_afull_thr);    // old thresholds this edge
      m_aempty = (mdl_q.size() <= m_aempty_thr);
      if (cfg_we_i) begin
         if (cfg_sel_i == REG_AFULL) m_afull_thr = int'(cfg_wdata_i);
         else m_aempty_thr = int'(cfg_wdata_i);
      end
   endtask

   task automatic compare(input string name, input int act, input int exp);
      checks++;
      if (act != exp) begin
         errors++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
      end
   endtask

   task automatic check_outputs();
      compare("count_o", int'(count_o), mdl_q.size());
      compare("full_o", int'(full_o), int'(m_full));
      compare("empty_o", int'(empty_o), int'(m_empty));
      compare("afull_o", int'(afull_o), int'(m_afull));
      compare("aempty_o", int'(aempty_o), int'(m_aempty));
      compare("wack_o", int'(wack_o), int'(exp_wack));
      compare("dvld_o", int'(dvld_o), int'(exp_dvld));
      compare("overflow_o", int'(overflow_o), int'(exp_ovf));
      compare("underflow_o", int'(underflow_o), int'(exp_unf));
      if (exp_dvld) compare("rdata_o", int'(rdata_o), int'(exp_rdata));
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   // drive at the rising edge, check mid-cycle once outputs settled
   task automatic drive_cycle(input logic w, input logic r, input logic [7:0] d,
                              input logic cw, input thresh_sel_e sel, input logic [7:0] cd);
      @(posedge pos_clk);
      update_model();
      we_i        <= w;
      re_i        <= r;
      wdata_i     <= d;
      cfg_we_i    <= cw;
      cfg_sel_i   <= sel;
      cfg_wdata_i <= cd;
      @(negedge pos_clk);
      check_outputs();
   endtask

   task automatic traffic(input logic w, input logic r);
      drive_cycle(w, r, rand_bits(8), 1'b0, REG_AFULL, 8'h00);
   endtask

   task automatic random_traffic(input int cycles);
      logic w, r;
      for (int i = 0; i < cycles; i++) begin
         w = lfsr_bit();
         r = lfsr_bit();
         traffic(w, r);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors > err_mark) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - err_mark);
      end else $display("test %s: ok", name);
      err_mark = errors;
   endtask

   initial begin
      aresetn <= 1'b0;
      we_i <= 1'b0;
      re_i <= 1'b0;
      wdata_i <= 8'h00;
      cfg_we_i <= 1'b0;
      cfg_sel_i <= REG_AFULL;
      cfg_wdata_i <= 8'h00;
      {m_full, m_afull, exp_wack, exp_dvld, exp_ovf, exp_unf} = '0;
      {m_empty, m_aempty} = 2'b11;
      exp_rdata = '0;
      m_afull_thr  = fifo_geom_pkg::DEF_AFULL;
      m_aempty_thr = fifo_geom_pkg::DEF_AEMPTY;

      repeat (16) @(posedge pos_clk);
      aresetn <= 1'b1;
      @(negedge pos_clk);
      check_outputs();                                       // reset values
      end_test("reset values");

      n = 0;
      while (!full_o && n < 4 * DEPTH) begin               // last write lands on full
         traffic(1'b1, 1'b0);
         n++;
      end
      if (!full_o) begin
         errors++;
         $display("FIFO did not report full within %0d writes", 4 * DEPTH);
      end
      traffic(1'b0, 1'b0);                                   // overflow shows here
      end_test("fill and overflow");

      n = 0;
      while (!empty_o && n < 4 * DEPTH) begin              // last read hits empty
         traffic(1'b0, 1'b1);
         n++;
      end
      if (!empty_o) begin
         errors++;
         $display("FIFO did not report empty within %0d reads", 4 * DEPTH);
      end
      traffic(1'b0, 1'b0);                                   // underflow shows here
      end_test("drain and underflow");

      random_traffic(2000);
      end_test("random traffic");

      // both new levels differ from the reset values
      drive_cycle(1'b0, 1'b0, 8'h00, 1'b1, REG_AFULL, 8'd4 + rand_bits(3));
      drive_cycle(1'b0, 1'b0, 8'h00, 1'b1, REG_AEMPTY, 8'd4 + rand_bits(2));
      random_traffic(500);
      end_test("threshold rewrite");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule : fifo_sc_tb
